// ==== src/ddpTypesPkg.sv ====
package ddpTypesPkg;

   // Network data word and field widths
   typedef logic [255:0] dataWord;
   typedef logic [3:0]   queueNum;
   typedef logic [5:0]   byteCount;
   typedef logic [55:0]  rdmapHeader;
   typedef logic [7:0]   ctrlByte;

   // Bytes of payload left in an sop word under the 88 header bits
   localparam byteCount sopPayloadBytes = 6'd21;
   localparam byteCount fullWordBytes = 6'd32;

   // One entry of the packet FIFO
   typedef struct packed {
      logic     sop;
      logic     eop;
      byteCount validBytes;
      dataWord  payload;
   } packetWord;

   // Header fields at the top of an sop word
   typedef struct packed {
      ctrlByte     ddpCtrl;
      ctrlByte     rdmapCtrl;
      logic [15:0] ddpHeader;
      rdmapHeader  rdmapHdr;
   } sopFields;

   // Towards header processing
   typedef struct packed {
      ctrlByte    control;
      rdmapHeader header;
   } headerOut;

   // End of a send packet as seen by the counters
   typedef struct packed {
      logic done;
      logic dropped;
   } sendEvent;

endpackage

// ==== src/ddpConfigPkg.sv ====
package ddpConfigPkg;

   typedef logic [1:0]  cfgAddr;
   typedef logic [15:0] cfgData;

   // RDMAP opcodes in the low nibble of rdmapCtrl
   localparam logic [3:0] reqOpcode = 4'd1;
   localparam logic [3:0] ackOpcode = 4'd2;
   localparam logic [3:0] sendOpcode = 4'd3;

   // Register map
   localparam cfgAddr queueEnableAddr = 2'd0;
   localparam cfgAddr sendCountAddr = 2'd1;
   localparam cfgAddr dropCountAddr = 2'd2;

   // All sixteen queues on
   localparam cfgData queueEnableReset = 16'hFFFF;

endpackage

// ==== src/packetFifo.sv ====
`timescale 1ns/1ps

module packetFifo #(
   parameter int FifoDepth = 8
) (
   input  logic                   clock,
   input  logic                   reset,
   input  logic                   inValid,
   input  ddpTypesPkg::packetWord inWord,
   output logic                   inReady,
   input  logic                   pop,
   output ddpTypesPkg::packetWord headWord,
   output logic                   empty
);

   localparam int PtrWidth = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
   localparam int CountWidth = $clog2(FifoDepth + 1);

   ddpTypesPkg::packetWord mem [FifoDepth];

   logic [PtrWidth-1:0]   wrPtr;
   logic [PtrWidth-1:0]   rdPtr;
   logic [CountWidth-1:0] count;
   logic                  doWrite;
   logic                  doRead;

   function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
      if (ptr == PtrWidth'(FifoDepth - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   assign inReady = (count != CountWidth'(FifoDepth));
   assign empty = (count == '0);
   assign headWord = mem[rdPtr];
   assign doWrite = inValid && inReady;
   assign doRead = pop && !empty;

   always_ff @(posedge clock) begin
      if (doWrite) begin
         mem[wrPtr] <= inWord;
      end
   end

   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end else begin
         if (doWrite) begin
            wrPtr <= nextPtr(wrPtr);
         end
         if (doRead) begin
            rdPtr <= nextPtr(rdPtr);
         end
         // Simultaneous write and pop leaves the count alone
         case ({doWrite, doRead})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// ==== src/ddpSegmentCutter.sv ====
`timescale 1ns/1ps

module ddpSegmentCutter (
   input  logic                   clock,
   input  logic                   reset,
   input  ddpTypesPkg::packetWord headWord,
   input  logic                   empty,
   output logic                   pop,
   input  logic [15:0]            queueEnable,
   output logic                   push,
   output ddpTypesPkg::dataWord   pushData,
   output ddpTypesPkg::queueNum   queue,
   output logic                   hdrValid,
   output ddpTypesPkg::headerOut  hdr,
   output ddpTypesPkg::sendEvent  sendEvent
);

   typedef enum logic [1:0] {
      idle,
      sendBody,
      sendFlush,
      skipBody
   } cutState;

   cutState state;
   cutState stateNext;

   ddpTypesPkg::sopFields sopHdr;
   logic [3:0]            opcode;
   logic                  isSend;
   logic                  isHeaderPkt;
   ddpTypesPkg::queueNum  sopQueue;

   // Bytes held back until a full output word is available
   logic [247:0]          resData;
   logic [4:0]            resCount;
   ddpTypesPkg::queueNum  sendQueue;
   logic                  sendEnabled;

   logic [247:0]          curRes;
   logic [4:0]            curCount;
   logic                  curEnabled;
   ddpTypesPkg::queueNum  curQueue;
   ddpTypesPkg::byteCount inCount;
   ddpTypesPkg::dataWord  inBytes;
   logic [511:0]          combined;
   logic [6:0]            total;
   logic [6:0]            excess;

   logic                  pushNext;
   ddpTypesPkg::dataWord  pushWordNext;
   logic                  doneNext;
   logic                  hdrNext;
   logic                  latchSop;
   logic [247:0]          resNext;
   logic [4:0]            countNext;

   function automatic ddpTypesPkg::dataWord byteMask(input ddpTypesPkg::byteCount n);
      ddpTypesPkg::dataWord m;
      m = '0;
      for (int i = 0; i < 32; i++) begin
         if (i < n) begin
            m[i*8 +: 8] = 8'hFF;
         end
      end
      return m;
   endfunction

   assign sopHdr = headWord.payload[255:168];
   assign opcode = sopHdr.rdmapCtrl[3:0];
   assign isSend = (opcode == ddpConfigPkg::sendOpcode);
   assign isHeaderPkt = (opcode == ddpConfigPkg::reqOpcode) ||
                        (opcode == ddpConfigPkg::ackOpcode);
   assign sopQueue = sopHdr.ddpHeader[3:0];

   always_comb begin
      if (headWord.eop) begin
         inCount = headWord.validBytes;
      end else if (headWord.sop) begin
         inCount = ddpTypesPkg::sopPayloadBytes;
      end else begin
         inCount = ddpTypesPkg::fullWordBytes;
      end
   end

   // Payload bytes of the head word aligned to byte 0 with unused bytes zeroed
   assign inBytes = (headWord.sop ? {88'b0, headWord.payload[167:0]} : headWord.payload) &
                    byteMask(inCount);

   // Residue only counts inside a send packet
   assign curRes = (state == idle) ? '0 : resData;
   assign curCount = (state == idle) ? '0 : resCount;
   assign curEnabled = (state == idle) ? queueEnable[sopQueue] : sendEnabled;
   assign curQueue = (state == idle) ? sopQueue : sendQueue;

   assign combined = {264'b0, curRes} | ({256'b0, inBytes} << {curCount, 3'b000});
   assign total = {2'b00, curCount} + {1'b0, inCount};
   assign excess = total - 7'd32;

   always_comb begin
      stateNext = state;
      pop = 1'b0;
      pushNext = 1'b0;
      pushWordNext = combined[255:0];
      doneNext = 1'b0;
      hdrNext = 1'b0;
      latchSop = 1'b0;
      resNext = resData;
      countNext = resCount;
      case (state)
         idle: begin
            if (!empty) begin
               pop = 1'b1;
               if (headWord.sop && isSend) begin
                  latchSop = 1'b1;
                  if (headWord.eop) begin
                     pushNext = curEnabled && (total != 7'd0);
                     doneNext = 1'b1;
                  end else begin
                     resNext = combined[247:0];
                     countNext = total[4:0];
                     stateNext = sendBody;
                  end
               end else if (headWord.sop) begin
                  hdrNext = isHeaderPkt;
                  if (!headWord.eop) begin
                     stateNext = skipBody;
                  end
               end
            end
         end
         sendBody: begin
            if (!empty) begin
               if (headWord.eop && (total > 7'd32)) begin
                  // Push a full word now and keep the eop word at the head one more cycle
                  pushNext = curEnabled;
                  resNext = combined[503:256];
                  countNext = excess[4:0];
                  stateNext = sendFlush;
               end else begin
                  pop = 1'b1;
                  pushNext = curEnabled && (total != 7'd0);
                  resNext = combined[503:256];
                  countNext = excess[4:0];
                  if (headWord.eop) begin
                     doneNext = 1'b1;
                     stateNext = idle;
                  end
               end
            end
         end
         sendFlush: begin
            pop = 1'b1;
            pushNext = curEnabled;
            pushWordNext = {8'b0, resData};
            doneNext = 1'b1;
            stateNext = idle;
         end
         skipBody: begin
            if (!empty) begin
               pop = 1'b1;
               if (headWord.eop) begin
                  stateNext = idle;
               end
            end
         end
         default: stateNext = idle;
      endcase
   end

   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         state <= idle;
         resCount <= '0;
         sendEnabled <= 1'b0;
         push <= 1'b0;
         hdrValid <= 1'b0;
         sendEvent <= '0;
      end else begin
         state <= stateNext;
         resCount <= countNext;
         push <= pushNext;
         hdrValid <= hdrNext;
         sendEvent.done <= doneNext;
         sendEvent.dropped <= doneNext && !curEnabled;
         if (latchSop) begin
            sendEnabled <= queueEnable[sopQueue];
         end
      end
   end

   always_ff @(posedge clock) begin
      resData <= resNext;
      if (latchSop) begin
         sendQueue <= sopQueue;
      end
      if (pushNext) begin
         pushData <= pushWordNext;
         queue <= curQueue;
      end
      if (hdrNext) begin
         hdr.control <= sopHdr.rdmapCtrl;
         hdr.header <= sopHdr.rdmapHdr;
      end
   end

endmodule

// ==== src/queueConfigRegs.sv ====
`timescale 1ns/1ps

module queueConfigRegs (
   input  logic                  clock,
   input  logic                  reset,
   input  logic                  cfgReq,
   input  logic                  cfgWrite,
   input  ddpConfigPkg::cfgAddr  cfgAddr,
   input  ddpConfigPkg::cfgData  cfgWriteData,
   output logic                  cfgAck,
   output ddpConfigPkg::cfgData  cfgReadData,
   input  ddpTypesPkg::sendEvent sendEvent,
   output ddpConfigPkg::cfgData  queueEnable
);

   typedef enum logic {
      waitReq,
      ackHeld
   } ackState;

   ackState state;

   ddpConfigPkg::cfgData sendCount;
   ddpConfigPkg::cfgData dropCount;
   logic                 access;
   logic                 clearSend;
   logic                 clearDrop;

   // Access happens once on the cycle the request is first seen
   assign access = (state == waitReq) && cfgReq;
   assign clearSend = access && cfgWrite && (cfgAddr == ddpConfigPkg::sendCountAddr);
   assign clearDrop = access && cfgWrite && (cfgAddr == ddpConfigPkg::dropCountAddr);
   assign cfgAck = (state == ackHeld);

   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         state <= waitReq;
         queueEnable <= ddpConfigPkg::queueEnableReset;
         sendCount <= '0;
         dropCount <= '0;
      end else begin
         if (access) begin
            state <= ackHeld;
         end else if ((state == ackHeld) && !cfgReq) begin
            state <= waitReq;
         end
         if (access && cfgWrite && (cfgAddr == ddpConfigPkg::queueEnableAddr)) begin
            queueEnable <= cfgWriteData;
         end
         // Saturating counters where a host clear wins over an event
         if (clearSend) begin
            sendCount <= '0;
         end else if (sendEvent.done && !sendEvent.dropped && (sendCount != '1)) begin
            sendCount <= sendCount + 1'b1;
         end
         if (clearDrop) begin
            dropCount <= '0;
         end else if (sendEvent.done && sendEvent.dropped && (dropCount != '1)) begin
            dropCount <= dropCount + 1'b1;
         end
      end
   end

   always_ff @(posedge clock) begin
      if (access) begin
         case (cfgAddr)
            ddpConfigPkg::queueEnableAddr: cfgReadData <= queueEnable;
            ddpConfigPkg::sendCountAddr:   cfgReadData <= sendCount;
            ddpConfigPkg::dropCountAddr:   cfgReadData <= dropCount;
            default:                       cfgReadData <= '0;
         endcase
      end
   end

endmodule

// ==== src/ddpReceiveTop.sv ====
`timescale 1ns/1ps

module ddpReceiveTop #(
   parameter int FifoDepth = 8
) (
   input  logic                   clock,
   input  logic                   reset,
   input  logic                   inValid,
   input  ddpTypesPkg::packetWord inWord,
   output logic                   inReady,
   output logic                   push,
   output ddpTypesPkg::dataWord   pushData,
   output ddpTypesPkg::queueNum   queue,
   output logic                   hdrValid,
   output ddpTypesPkg::headerOut  hdr,
   input  logic                   cfgReq,
   input  logic                   cfgWrite,
   input  ddpConfigPkg::cfgAddr   cfgAddr,
   input  ddpConfigPkg::cfgData   cfgWriteData,
   output logic                   cfgAck,
   output ddpConfigPkg::cfgData   cfgReadData
);

   ddpTypesPkg::packetWord headWord;
   logic                   empty;
   logic                   pop;
   logic [15:0]            queueEnable;
   ddpTypesPkg::sendEvent  sendEvent;

   packetFifo #(
      .FifoDepth(FifoDepth)
   ) u_packetFifo (
      .clock   (clock),
      .reset   (reset),
      .inValid (inValid),
      .inWord  (inWord),
      .inReady (inReady),
      .pop     (pop),
      .headWord(headWord),
      .empty   (empty)
   );

   ddpSegmentCutter u_ddpSegmentCutter (
      .clock      (clock),
      .reset      (reset),
      .headWord   (headWord),
      .empty      (empty),
      .pop        (pop),
      .queueEnable(queueEnable),
      .push       (push),
      .pushData   (pushData),
      .queue      (queue),
      .hdrValid   (hdrValid),
      .hdr        (hdr),
      .sendEvent  (sendEvent)
   );

   queueConfigRegs u_queueConfigRegs (
      .clock       (clock),
      .reset       (reset),
      .cfgReq      (cfgReq),
      .cfgWrite    (cfgWrite),
      .cfgAddr     (cfgAddr),
      .cfgWriteData(cfgWriteData),
      .cfgAck      (cfgAck),
      .cfgReadData (cfgReadData),
      .sendEvent   (sendEvent),
      .queueEnable (queueEnable)
   );

endmodule

// ==== test/ddpReceiveTb.sv ====
`timescale 1ns/1ps

module ddpReceiveTb;

   localparam int NumTests = 28;
   localparam int ClockPeriod = 40;
   localparam logic [2:0] kindSend = 3'd0;
   localparam logic [2:0] kindReq = 3'd1;
   localparam logic [2:0] kindAck = 3'd2;
   localparam logic [2:0] kindWrite = 3'd3;
   localparam logic [2:0] kindRead = 3'd4;
   // Gap drawn from the LFSR as 0 to 7 cycles
   localparam logic [7:0] randomGap = 8'hFF;

   typedef struct packed {
      logic [2:0]  kind;
      logic [3:0]  queue;
      logic [7:0]  length;
      logic [7:0]  gap;
      logic [15:0] value;
   } testRow;

   logic                   clock;
   logic                   reset;
   logic                   inValid;
   ddpTypesPkg::packetWord inWord;
   logic                   inReady;
   logic                   push;
   ddpTypesPkg::dataWord   pushData;
   ddpTypesPkg::queueNum   queue;
   logic                   hdrValid;
   ddpTypesPkg::headerOut  hdr;
   logic                   cfgReq;
   logic                   cfgWrite;
   ddpConfigPkg::cfgAddr   cfgAddr;
   ddpConfigPkg::cfgData   cfgWriteData;
   logic                   cfgAck;
   ddpConfigPkg::cfgData   cfgReadData;

   string        testName [NumTests];
   testRow       rows [NumTests];
   int           rowErrors [NumTests];
   int           outstanding [NumTests];
   int           rowCount;
   int           rowsApplied;
   int           nextReport;
   int           errorCount;
   int           passCount;
   logic [15:0]  lfsrState;
   logic [15:0]  modelEnable;
   bit           tableReady;

   logic [255:0] expPushData [$];
   logic [3:0]   expPushQueue [$];
   int           expPushRow [$];
   logic [63:0]  expHdr [$];
   int           expHdrRow [$];

   ddpReceiveTop #(
      .FifoDepth(4)
   ) u_ddpReceiveTop (
      .clock       (clock),
      .reset       (reset),
      .inValid     (inValid),
      .inWord      (inWord),
      .inReady     (inReady),
      .push        (push),
      .pushData    (pushData),
      .queue       (queue),
      .hdrValid    (hdrValid),
      .hdr         (hdr),
      .cfgReq      (cfgReq),
      .cfgWrite    (cfgWrite),
      .cfgAddr     (cfgAddr),
      .cfgWriteData(cfgWriteData),
      .cfgAck      (cfgAck),
      .cfgReadData (cfgReadData)
   );

   always #(ClockPeriod / 2) clock = ~clock;

   // Fibonacci LFSR with taps 16 14 13 11 and one step per bit
   function automatic logic [31:0] randomBits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
         lfsrState = {lfsrState[14:0], fb};
         r = {r[30:0], fb};
      end
      return r;
   endfunction

   function automatic int wordCount(input int len);
      if (len <= 21) begin
         return 1;
      end
      return 1 + (len - 21 + 31) / 32;
   endfunction

   function automatic int rowWords(input int i);
      if (rows[i].kind >= kindWrite) begin
         return 0;
      end
      return wordCount(int'(rows[i].length));
   endfunction

   task automatic checkValue(input int row, input string what,
                             input logic [255:0] expected, input logic [255:0] actual);
      if (expected !== actual) begin
         $display("[ERROR] %s %s: expected %0h, actual %0h", testName[row], what,
                  expected, actual);
         rowErrors[row]++;
         errorCount++;
      end
   endtask

   // Rows finish in order once stimulus is done and all their outputs are seen
   task automatic reportFinished();
      while ((nextReport < rowsApplied) && (outstanding[nextReport] == 0)) begin
         if (rowErrors[nextReport] == 0) begin
            $display("[PASS] %s", testName[nextReport]);
            passCount++;
         end else begin
            $display("[FAIL] %s, %0d errors", testName[nextReport], rowErrors[nextReport]);
         end
         nextReport++;
      end
   endtask

   task automatic addRow(input string name, input logic [2:0] kind, input int q,
                         input int len, input int gap, input int value);
      testName[rowCount] = name;
      rows[rowCount].kind = kind;
      rows[rowCount].queue = 4'(q);
      rows[rowCount].length = 8'(len);
      rows[rowCount].gap = 8'(gap);
      rows[rowCount].value = 16'(value);
      rowErrors[rowCount] = 0;
      outstanding[rowCount] = 0;
      rowCount++;
   endtask

   // Config rows use the queue column as register address
   task automatic buildTable();
      addRow("readEnableReset", kindRead, 0, 0, 0, 16'hFFFF);
      addRow("send5", kindSend, 1, 5, 0, 0);
      addRow("send21", kindSend, 2, 21, 2, 0);
      addRow("send22", kindSend, 3, 22, 0, 0);
      addRow("send53", kindSend, 4, 53, 1, 0);
      addRow("send64", kindSend, 5, 64, 0, 0);
      addRow("send100", kindSend, 6, 100, 3, 0);
      addRow("request40", kindReq, 0, 40, 0, 0);
      addRow("ack5", kindAck, 0, 5, 2, 0);
      addRow("readSendCount", kindRead, 1, 0, 0, 6);
      addRow("writeEnable", kindWrite, 0, 0, 0, 16'hFF7F);
      addRow("readEnable", kindRead, 0, 0, 0, 16'hFF7F);
      addRow("sendDisabled", kindSend, 7, 40, 0, 0);
      addRow("ackAfterDrop", kindAck, 0, 5, 0, 0);
      addRow("readDropCount", kindRead, 2, 0, 0, 1);
      addRow("readSendKept", kindRead, 1, 0, 0, 6);
      addRow("sendEnabled", kindSend, 8, 30, 0, 0);
      addRow("backToBackSend", kindSend, 9, 70, 0, 0);
      addRow("backToBackReq", kindReq, 0, 12, 0, 0);
      addRow("gapSend33", kindSend, 10, 33, randomGap, 0);
      addRow("gapAck", kindAck, 0, 5, randomGap, 0);
      addRow("gapSend1", kindSend, 11, 1, randomGap, 0);
      addRow("readSendAfter", kindRead, 1, 0, 0, 10);
      addRow("clearSendCount", kindWrite, 1, 0, 0, 0);
      addRow("readSendCleared", kindRead, 1, 0, 0, 0);
      addRow("clearDropCount", kindWrite, 2, 0, 0, 0);
      addRow("readDropCleared", kindRead, 2, 0, 0, 0);
      addRow("readUnknownAddr", kindRead, 3, 0, 0, 0);
   endtask

   // Called on a falling edge, returns on the falling edge after the word is taken
   task automatic offerWord(input ddpTypesPkg::packetWord w);
      inWord = w;
      inValid = 1'b1;
      while (!inReady) begin
         @(negedge clock);
      end
      @(negedge clock);
   endtask

   task automatic applyPacket(input int row);
      ddpTypesPkg::sopFields  fields;
      ddpTypesPkg::packetWord word;
      logic [7:0]             bytes [$];
      logic [255:0]           expWord;
      logic [31:0]            tmp;
      logic [31:0]            hdrHigh;
      logic [3:0]             opcode;
      int                     len;
      int                     words;
      int                     pos;
      int                     take;
      int                     gap;
      len = int'(rows[row].length);
      words = wordCount(len);
      case (rows[row].kind)
         kindReq: opcode = ddpConfigPkg::reqOpcode;
         kindAck: opcode = ddpConfigPkg::ackOpcode;
         default: opcode = ddpConfigPkg::sendOpcode;
      endcase
      hdrHigh = randomBits(24);
      tmp = randomBits(32);
      fields.ddpCtrl = 8'h41;
      fields.rdmapCtrl = {4'h4, opcode};
      fields.ddpHeader = {12'h0D0, rows[row].queue};
      fields.rdmapHdr = {hdrHigh[23:0], tmp};
      for (int i = 0; i < len; i++) begin
         tmp = randomBits(8);
         bytes.push_back(tmp[7:0]);
      end
      // Expected outputs go in before any word is offered
      if (rows[row].kind == kindSend) begin
         if (modelEnable[rows[row].queue]) begin
            for (int k = 0; k < (len + 31) / 32; k++) begin
               expWord = '0;
               for (int b = 0; (b < 32) && (k * 32 + b < len); b++) begin
                  expWord[b*8 +: 8] = bytes[k*32+b];
               end
               expPushData.push_back(expWord);
               expPushQueue.push_back(rows[row].queue);
               expPushRow.push_back(row);
               outstanding[row]++;
            end
         end
      end else begin
         expHdr.push_back({fields.rdmapCtrl, fields.rdmapHdr});
         expHdrRow.push_back(row);
         outstanding[row]++;
      end
      pos = 0;
      for (int w = 0; w < words; w++) begin
         word = '0;
         word.sop = (w == 0);
         word.eop = (w == words - 1);
         if (w == 0) begin
            take = (len < 21) ? len : 21;
         end else begin
            take = (len - pos < 32) ? len - pos : 32;
         end
         for (int b = 0; b < take; b++) begin
            word.payload[b*8 +: 8] = bytes[pos+b];
         end
         if (w == 0) begin
            word.payload[255:168] = fields;
         end
         word.validBytes = word.eop ? 6'(take) : ((w == 0) ? 6'd21 : 6'd32);
         pos += take;
         offerWord(word);
      end
      inValid = 1'b0;
      inWord = '0;
      rowsApplied++;
      reportFinished();
      gap = int'(rows[row].gap);
      if (rows[row].gap == randomGap) begin
         tmp = randomBits(3);
         gap = int'(tmp[2:0]);
      end
      repeat (gap) @(negedge clock);
   endtask

   task automatic drainOutputs();
      while ((expPushData.size() != 0) || (expHdr.size() != 0)) begin
         @(negedge clock);
      end
      // One more cycle lets the counters take the last send event
      @(negedge clock);
   endtask

   task automatic cfgAccess(input int row);
      logic write;
      int   waited;
      write = (rows[row].kind == kindWrite);
      drainOutputs();
      checkValue(row, "cfgAck before request", 256'(0), 256'(cfgAck));
      cfgWrite = write;
      cfgAddr = rows[row].queue[1:0];
      cfgWriteData = write ? rows[row].value : 16'h0000;
      cfgReq = 1'b1;
      waited = 0;
      while (!cfgAck) begin
         @(negedge clock);
         waited++;
      end
      checkValue(row, "cfgAck rise delay", 256'(1), 256'(waited));
      if (!write) begin
         checkValue(row, "cfgReadData", 256'(rows[row].value), 256'(cfgReadData));
      end
      cfgReq = 1'b0;
      waited = 0;
      while (cfgAck) begin
         @(negedge clock);
         waited++;
      end
      checkValue(row, "cfgAck fall delay", 256'(1), 256'(waited));
      cfgWrite = 1'b0;
      cfgAddr = '0;
      cfgWriteData = '0;
      if (write && (rows[row].queue[1:0] == ddpConfigPkg::queueEnableAddr)) begin
         modelEnable = rows[row].value;
      end
      rowsApplied++;
      reportFinished();
   endtask

   always @(negedge clock) begin : outputMonitor
      int row;
      if (reset) begin
         if (push) begin
            if (expPushData.size() == 0) begin
               $display("Unexpected push of data %0h on queue %0d", pushData, queue);
               errorCount++;
            end else begin
               row = expPushRow.pop_front();
               checkValue(row, "pushData", expPushData.pop_front(), pushData);
               checkValue(row, "queue", 256'(expPushQueue.pop_front()), 256'(queue));
               outstanding[row]--;
            end
         end
         if (hdrValid) begin
            if (expHdr.size() == 0) begin
               $display("Unexpected header output %0h", hdr);
               errorCount++;
            end else begin
               row = expHdrRow.pop_front();
               checkValue(row, "hdr", 256'(expHdr.pop_front()), 256'(hdr));
               outstanding[row]--;
            end
         end
         reportFinished();
      end
   end

   initial begin : watchdog
      longint budget;
      wait (tableReady);
      budget = 4;
      for (int i = 0; i < rowCount; i++) begin
         budget += rowWords(i) + ((rows[i].gap == randomGap) ? 7 : int'(rows[i].gap)) + 10;
      end
      #(budget * ClockPeriod);
      $display("Watchdog timeout, the tests did not finish within %0d cycles", budget);
      $display("Simulation failed");
      $finish;
   end

   initial begin
      clock = 1'b0;
      reset = 1'b0;
      inValid = 1'b0;
      inWord = '0;
      cfgReq = 1'b0;
      cfgWrite = 1'b0;
      cfgAddr = '0;
      cfgWriteData = '0;
      rowCount = 0;
      rowsApplied = 0;
      nextReport = 0;
      errorCount = 0;
      passCount = 0;
      lfsrState = 16'd49527;
      modelEnable = ddpConfigPkg::queueEnableReset;
      buildTable();
      tableReady = 1'b1;
      repeat (4) @(posedge clock);
      @(negedge clock);
      reset = 1'b1;
      @(negedge clock);
      // FIFO is empty after reset and takes words
      checkValue(0, "inReady after reset", 256'(1), 256'(inReady));
      for (int i = 0; i < rowCount; i++) begin
         if (rows[i].kind >= kindWrite) begin
            cfgAccess(i);
         end else begin
            applyPacket(i);
         end
      end
      drainOutputs();
      reportFinished();
      $display("Tests: %0d, passed: %0d, errors: %0d", rowCount, passCount, errorCount);
      if ((errorCount == 0) && (passCount == rowCount)) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// ==== list.f ====
src/ddpTypesPkg.sv
src/ddpConfigPkg.sv
src/packetFifo.sv
src/ddpSegmentCutter.sv
src/queueConfigRegs.sv
src/ddpReceiveTop.sv
test/ddpReceiveTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f list.f --top-module ddpReceiveTb \
   -Mdir obj_dir -o simDdp \
   && ./obj_dir/simDdp 2>&1 | tee sim.log \
   || { echo "Build or run error"; exit 1; }
grep -q "Simulation failed" sim.log && { echo "Failure found in sim.log"; exit 1; } \
   || { echo "No failure found in sim.log"; exit 0; }
